// ==== hdl/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

    // One character on the serial line
    typedef logic [7:0] uart_byte_t;

    // Index of a data bit within a frame
    typedef logic [2:0] bit_idx_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START_BIT,
        TX_DATA_BIT,
        TX_STOP_BIT
    } tx_state_t;

    // Sent in place of a byte whose stop bit was low
    localparam uart_byte_t BAD_FRAME_CHAR = 8'h3f;

endpackage

`default_nettype wire

// ==== hdl/byte_link_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// One byte with its error flag, passed under a four-phase req/ack handshake
interface byte_link_if import uart_pkg::*; ();

    logic       req;
    uart_byte_t data;
    logic       frame_err;
    logic       ack;

    modport source (
        output req,
        output data,
        output frame_err,
        input  ack
    );

    modport sink (
        input  req,
        input  data,
        input  frame_err,
        output ack
    );

endinterface

`default_nettype wire

// ==== hdl/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx import uart_pkg::*; #(
    parameter int CLK_PER_BIT = 16
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        rx,
    byte_link_if.source out
);

    localparam int CTR_W = $clog2(CLK_PER_BIT);
    localparam logic [CTR_W-1:0] BIT_LAST = CTR_W'(CLK_PER_BIT - 1);
    localparam logic [CTR_W-1:0] HALF_LAST = CTR_W'(CLK_PER_BIT / 2 - 1);

    logic [1:0]       sync;
    logic             rx_s;
    logic             rx_prev;
    rx_state_t        state;
    logic [CTR_W-1:0] ctr;
    bit_idx_t         bit_idx;
    uart_byte_t       shreg;
    logic             data_sample;
    logic             stop_sample;
    logic             link_free;

    assign rx_s = sync[1];
    assign data_sample = (state == RX_DATA) && (ctr == BIT_LAST);
    assign stop_sample = (state == RX_STOP) && (ctr == BIT_LAST);

    // The previous byte must be fully handed on before a new one is offered
    assign link_free = !out.req && !out.ack;

    // Synchroniser and edge detector start at the idle line level
    always_ff @(posedge clk) begin
        if (rst) begin
            sync    <= 2'b11;
            rx_prev <= 1'b1;
        end else begin
            sync    <= {sync[0], rx};
            rx_prev <= rx_s;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= RX_IDLE;
            ctr     <= '0;
            bit_idx <= '0;
            out.req <= 1'b0;
        end else begin
            if (out.req && out.ack) begin
                out.req <= 1'b0;
            end

            case (state)
                RX_IDLE: begin
                    ctr <= '0;
                    // Only a falling edge starts a frame, so a low stop bit
                    // that lingers is not taken for a new start bit
                    if (rx_prev && !rx_s) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    ctr <= ctr + 1'b1;
                    if (ctr == HALF_LAST) begin
                        ctr     <= '0;
                        bit_idx <= '0;
                        // A line that is high again at mid start bit was a glitch
                        state   <= rx_s ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    ctr <= ctr + 1'b1;
                    if (data_sample) begin
                        ctr     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    ctr <= ctr + 1'b1;
                    if (stop_sample) begin
                        state <= RX_IDLE;
                        if (link_free) begin
                            out.req <= 1'b1;
                        end
                    end
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // Data arrives LSB first, so it enters at the top and shifts down
    always_ff @(posedge clk) begin
        if (data_sample) begin
            shreg <= {rx_s, shreg[7:1]};
        end
        if (stop_sample && link_free) begin
            out.data      <= shreg;
            out.frame_err <= !rx_s;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/case_filter.sv ====
`timescale 1ns/1ps
`default_nettype none

module case_filter import uart_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    byte_link_if.sink   in,
    byte_link_if.source out
);

    uart_byte_t data_q;
    logic       pending;
    logic       out_busy;
    logic       take;

    // Lowercase letters become uppercase, a bad frame becomes the marker
    function automatic uart_byte_t map_byte(input uart_byte_t d, input logic err);
        if (err) begin
            return BAD_FRAME_CHAR;
        end
        if (d >= 8'h61 && d <= 8'h7a) begin
            return d & ~8'h20;
        end
        return d;
    endfunction

    // Output handshake still open, from the moment a byte is taken
    assign out_busy = pending || out.req || out.ack;
    assign take = in.req && !in.ack && !out_busy;

    assign out.data = data_q;
    assign out.frame_err = 1'b0;

    always_ff @(posedge clk) begin
        if (rst) begin
            in.ack  <= 1'b0;
            out.req <= 1'b0;
            pending <= 1'b0;
        end else begin
            if (take) begin
                in.ack  <= 1'b1;
                pending <= 1'b1;
            end else if (in.ack && !in.req) begin
                in.ack <= 1'b0;
            end

            // Req follows ack by one cycle, once the mapped byte is in data_q
            if (pending) begin
                out.req <= 1'b1;
                pending <= 1'b0;
            end else if (out.req && out.ack) begin
                out.req <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            data_q <= map_byte(in.data, in.frame_err);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx import uart_pkg::*; #(
    parameter int CLK_PER_BIT = 16
) (
    input  logic      clk,
    input  logic      rst,
    byte_link_if.sink in,
    input  logic      block,
    output logic      tx,
    output logic      busy
);

    localparam int CTR_W = $clog2(CLK_PER_BIT);
    localparam logic [CTR_W-1:0] BIT_LAST = CTR_W'(CLK_PER_BIT - 1);

    tx_state_t        state;
    logic [CTR_W-1:0] ctr;
    bit_idx_t         bit_idx;
    bit_idx_t         next_idx;
    uart_byte_t       data_q;
    logic             block_q;
    logic             accept;

    assign next_idx = bit_idx + 1'b1;
    assign accept = (state == TX_IDLE) && !block_q && in.req && !in.ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= TX_IDLE;
            ctr     <= '0;
            bit_idx <= '0;
            tx      <= 1'b1;
            busy    <= 1'b0;
            in.ack  <= 1'b0;
            block_q <= 1'b0;
        end else begin
            block_q <= block;

            if (in.ack && !in.req) begin
                in.ack <= 1'b0;
            end

            case (state)
                TX_IDLE: begin
                    tx      <= 1'b1;
                    ctr     <= '0;
                    bit_idx <= '0;
                    busy    <= block_q;
                    // Start bit goes out in the same cycle as ack
                    if (accept) begin
                        in.ack <= 1'b1;
                        busy   <= 1'b1;
                        tx     <= 1'b0;
                        state  <= TX_START_BIT;
                    end
                end
                TX_START_BIT: begin
                    ctr <= ctr + 1'b1;
                    if (ctr == BIT_LAST) begin
                        ctr   <= '0;
                        tx    <= data_q[0];
                        state <= TX_DATA_BIT;
                    end
                end
                TX_DATA_BIT: begin
                    ctr <= ctr + 1'b1;
                    if (ctr == BIT_LAST) begin
                        ctr     <= '0;
                        bit_idx <= next_idx;
                        if (bit_idx == 3'd7) begin
                            tx    <= 1'b1;
                            state <= TX_STOP_BIT;
                        end else begin
                            tx <= data_q[next_idx];
                        end
                    end
                end
                TX_STOP_BIT: begin
                    ctr <= ctr + 1'b1;
                    if (ctr == BIT_LAST) begin
                        // Stay busy without a gap if block came up meanwhile
                        busy  <= block_q;
                        state <= TX_IDLE;
                    end
                end
                default: begin
                    state <= TX_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            data_q <= in.data;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/uart_echo_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_echo_top #(
    parameter int CLK_PER_BIT = 16
) (
    input  logic clk,
    input  logic rst,
    input  logic rx,
    input  logic block,
    output logic tx,
    output logic busy
);

    // Receiver to filter
    byte_link_if rx_link ();

    // Filter to transmitter
    byte_link_if tx_link ();

    uart_rx #(
        .CLK_PER_BIT (CLK_PER_BIT)
    ) u_uart_rx (
        .clk (clk),
        .rst (rst),
        .rx  (rx),
        .out (rx_link.source)
    );

    case_filter u_case_filter (
        .clk (clk),
        .rst (rst),
        .in  (rx_link.sink),
        .out (tx_link.source)
    );

    uart_tx #(
        .CLK_PER_BIT (CLK_PER_BIT)
    ) u_uart_tx (
        .clk   (clk),
        .rst   (rst),
        .in    (tx_link.sink),
        .block (block),
        .tx    (tx),
        .busy  (busy)
    );

endmodule

`default_nettype wire

// ==== testbench/uart_echo_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_echo_assert (
    input logic       clk,
    input logic       rst,
    input logic       rx_req,
    input logic [7:0] rx_data,
    input logic       rx_err,
    input logic       rx_ack,
    input logic       tx_req,
    input logic [7:0] tx_data,
    input logic       tx_err,
    input logic       tx_ack,
    input logic       tx,
    input logic       busy
);

    int failures = 0;

    // Data and error flag hold for as long as a request is open
    rx_data_stable: assert property (@(posedge clk) disable iff (rst)
        rx_req |=> (!rx_req || ($stable(rx_data) && $stable(rx_err))))
    else begin
        failures++;
        $error("rx_link data changed while req was high");
    end

    tx_data_stable: assert property (@(posedge clk) disable iff (rst)
        tx_req |=> (!tx_req || ($stable(tx_data) && $stable(tx_err))))
    else begin
        failures++;
        $error("tx_link data changed while req was high");
    end

    rx_req_waits: assert property (@(posedge clk) disable iff (rst)
        (!rx_req && rx_ack) |=> !rx_req)
    else begin
        failures++;
        $error("rx_link req rose while ack was still high");
    end

    tx_req_waits: assert property (@(posedge clk) disable iff (rst)
        (!tx_req && tx_ack) |=> !tx_req)
    else begin
        failures++;
        $error("tx_link req rose while ack was still high");
    end

    // The line rests high whenever the transmitter is not busy
    tx_idle_high: assert property (@(posedge clk) disable iff (rst)
        !busy |-> tx)
    else begin
        failures++;
        $error("tx was low while busy was low");
    end

endmodule

bind uart_echo_top uart_echo_assert u_echo_assert (
    .clk     (clk),
    .rst     (rst),
    .rx_req  (rx_link.req),
    .rx_data (rx_link.data),
    .rx_err  (rx_link.frame_err),
    .rx_ack  (rx_link.ack),
    .tx_req  (tx_link.req),
    .tx_data (tx_link.data),
    .tx_err  (tx_link.frame_err),
    .tx_ack  (tx_link.ack),
    .tx      (tx),
    .busy    (busy)
);

`default_nettype wire

// ==== testbench/uart_echo_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_echo_checker import uart_pkg::*; #(
    parameter int CLK_PER_BIT = 16
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       tx,
    input  logic       busy,
    input  logic       block,
    input  logic       quiet,
    input  logic       exp_push,
    input  uart_byte_t exp_data,
    input  logic       test_end,
    input  int         test_num,
    output int         frames_seen,
    output int         starts_seen,
    output int         error_count,
    output int         tests_passed,
    output int         tests_failed
);

    uart_byte_t exp_q[$];
    logic       tx_prev;
    logic       in_frame;
    logic [9:0] bits;
    int         cnt;
    int         block_cycles;
    logic       idle_reported;
    int         errs_at_start;
    int         frames_at_start;

    task automatic check_frame(input logic [9:0] f);
        uart_byte_t want;
        frames_seen++;
        if (f[0] !== 1'b0) begin
            error_count++;
            $display("Error at %0d ns: start bit of an echoed frame is not low", $time);
        end
        if (f[9] !== 1'b1) begin
            error_count++;
            $display("Error at %0d ns: stop bit of an echoed frame is not high", $time);
        end
        if (exp_q.size() == 0) begin
            error_count++;
            $display("Error at %0d ns: byte %02h came out on tx with no echo expected",
                     $time, f[8:1]);
        end else begin
            want = exp_q.pop_front();
            if (f[8:1] !== want) begin
                error_count++;
                $display("Fail at %0d ns: tx byte expected %02h, got %02h", $time, want, f[8:1]);
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            exp_q.delete();
            tx_prev = 1'b1;
            in_frame = 1'b0;
            cnt = 0;
            bits = '0;
            block_cycles = 0;
            idle_reported = 1'b0;
            frames_seen = 0;
            starts_seen = 0;
            error_count = 0;
            tests_passed = 0;
            tests_failed = 0;
            errs_at_start = 0;
            frames_at_start = 0;
        end else begin
            if (exp_push) begin
                exp_q.push_back(exp_data);
            end

            block_cycles = block ? block_cycles + 1 : 0;
            if (quiet && !idle_reported && (tx !== 1'b1 || busy !== 1'b0)) begin
                error_count++;
                idle_reported = 1'b1;
                $display("Error at %0d ns: tx or busy moved while the line was idle", $time);
            end
            // Block needs two cycles to reach busy through its register
            if (block_cycles >= 3 && !idle_reported && (tx !== 1'b1 || busy !== 1'b1)) begin
                error_count++;
                idle_reported = 1'b1;
                $display("Error at %0d ns: tx sent or busy dropped while block was held", $time);
            end

            if (!in_frame) begin
                if (tx_prev && !tx) begin
                    in_frame = 1'b1;
                    cnt = 1;
                    starts_seen++;
                end
            end else begin
                cnt++;
                if (cnt % CLK_PER_BIT == CLK_PER_BIT / 2) begin
                    bits = {tx, bits[9:1]};
                    if (cnt / CLK_PER_BIT == 9) begin
                        in_frame = 1'b0;
                        check_frame(bits);
                    end
                end
            end
            tx_prev = tx;

            if (test_end) begin
                if (exp_q.size() != 0) begin
                    error_count++;
                    $display("Error at %0d ns: %0d expected bytes never came out on tx",
                             $time, exp_q.size());
                    exp_q.delete();
                end
                if (error_count == errs_at_start) begin
                    tests_passed++;
                    $display("Test %0d passed: %0d frames checked",
                             test_num, frames_seen - frames_at_start);
                end else begin
                    tests_failed++;
                    $display("Test %0d failed: %0d frames checked, %0d errors",
                             test_num, frames_seen - frames_at_start, error_count - errs_at_start);
                end
                idle_reported = 1'b0;
                errs_at_start = error_count;
                frames_at_start = frames_seen;
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/uart_echo_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_echo_tb import uart_pkg::*; ();

    localparam int CLK_PER_BIT = 16;
    localparam uart_byte_t ERR_ECHO = 8'h3f;
    localparam int TEST_FRAMES = 16 + 12 + 1 + 16;
    // Each frame costs one received frame plus its echo, with idle line around them
    localparam int CYCLE_LIMIT = TEST_FRAMES * 24 * CLK_PER_BIT + 4000;

    logic       clk;
    logic       rst;
    logic       rx;
    logic       block;
    logic       tx;
    logic       busy;

    logic       exp_push;
    uart_byte_t exp_data;
    logic       quiet;
    logic       test_end;
    int         test_num;
    int         frames_seen;
    int         starts_seen;
    int         error_count;
    int         tests_passed;
    int         tests_failed;

    logic [15:0] lfsr;
    logic [31:0] r;
    int          frames_sent;
    int          cycles = 0;
    int          total_errors;

    always #5 clk = ~clk;

    uart_echo_top #(
        .CLK_PER_BIT (CLK_PER_BIT)
    ) u_uart_echo_top (
        .clk   (clk),
        .rst   (rst),
        .rx    (rx),
        .block (block),
        .tx    (tx),
        .busy  (busy)
    );

    uart_echo_checker #(
        .CLK_PER_BIT (CLK_PER_BIT)
    ) u_checker (
        .clk          (clk),
        .rst          (rst),
        .tx           (tx),
        .busy         (busy),
        .block        (block),
        .quiet        (quiet),
        .exp_push     (exp_push),
        .exp_data     (exp_data),
        .test_end     (test_end),
        .test_num     (test_num),
        .frames_seen  (frames_seen),
        .starts_seen  (starts_seen),
        .error_count  (error_count),
        .tests_passed (tests_passed),
        .tests_failed (tests_failed)
    );

    // Taps 16, 14, 13 and 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // What the echo path should send back for one received frame
    function automatic uart_byte_t expected_echo(input uart_byte_t b, input logic bad);
        if (bad) begin
            return ERR_ECHO;
        end
        if (b >= "a" && b <= "z") begin
            return b - 8'h20;
        end
        return b;
    endfunction

    // Start bit, data LSB first, then a stop bit that is low for a bad frame
    // The start bit goes out on the current falling edge, right after any stop bit
    task automatic send_frame(input uart_byte_t b, input logic bad);
        logic [9:0] bits;
        bits = {~bad, b, 1'b0};
        exp_data = expected_echo(b, bad);
        exp_push = 1'b1;
        for (int i = 0; i < 10; i++) begin
            rx = bits[i];
            repeat (CLK_PER_BIT) begin
                @(negedge clk);
                exp_push = 1'b0;
            end
        end
        rx = 1'b1;
        frames_sent++;
    endtask

    task automatic wait_echo_done();
        while (frames_seen < frames_sent) begin
            @(negedge clk);
        end
        repeat (CLK_PER_BIT) @(negedge clk);
    endtask

    task automatic end_test(input int num);
        @(negedge clk);
        test_num = num;
        test_end = 1'b1;
        @(negedge clk);
        test_end = 1'b0;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        rx = 1'b1;
        block = 1'b0;
        exp_push = 1'b0;
        exp_data = '0;
        quiet = 1'b0;
        test_end = 1'b0;
        test_num = 0;
        lfsr = 16'd26142;
        frames_sent = 0;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        quiet = 1'b1;
        repeat (4 * CLK_PER_BIT) @(negedge clk);
        quiet = 1'b0;
        end_test(1);

        for (int i = 0; i < 16; i++) begin
            random_bits(8, r);
            // Every other byte lands in the lowercase range
            if (i % 2 == 1) begin
                r[7:0] = 8'h61 + r[7:0] % 8'd26;
            end
            send_frame(r[7:0], 1'b0);
            wait_echo_done();
        end
        end_test(2);

        for (int i = 0; i < 12; i++) begin
            random_bits(8, r);
            send_frame(r[7:0], i % 3 == 1);
            wait_echo_done();
        end
        end_test(3);

        block = 1'b1;
        repeat (4) @(negedge clk);
        random_bits(8, r);
        send_frame(r[7:0], 1'b0);
        // Long enough that an unblocked echo would already be over
        repeat (20 * CLK_PER_BIT) @(negedge clk);
        block = 1'b0;
        wait_echo_done();
        end_test(4);

        for (int i = 0; i < 16; i++) begin
            random_bits(8, r);
            send_frame(r[7:0], 1'b0);
            while (starts_seen < frames_sent) begin
                @(negedge clk);
            end
            random_bits(2, r);
            if (r[1:0] != 2'b00) begin
                random_bits(6, r);
                repeat (r[5:0]) @(negedge clk);
            end
        end
        wait_echo_done();
        end_test(5);

        repeat (2) @(negedge clk);
        total_errors = error_count + u_uart_echo_top.u_echo_assert.failures;
        $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, total_errors);
        if (tests_failed == 0 && total_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
hdl/uart_pkg.sv
hdl/byte_link_if.sv
hdl/uart_rx.sv
hdl/case_filter.sv
hdl/uart_tx.sv
hdl/uart_echo_top.sv
testbench/uart_echo_assert.sv
testbench/uart_echo_checker.sv
testbench/uart_echo_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the UART echo testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module uart_echo_tb -o uart_echo_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/uart_echo_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation passed"
exit 0
